//--- Makefile
TOP = fusion_mac_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test completed successfully" sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- rtl/bitbrick_cluster.sv
`timescale 1ns/1ps
`include "fusion_config.svh"

// one 4x4 multiplier built from four 2x2 bricks
// signedness of each half comes from the sign enables of this cluster
module bitbrick_cluster #(
    parameter int CLUSTER = 1
) (
    input  logic [`FU_NIB_W-1:0]   x,
    input  logic [`FU_NIB_W-1:0]   y,
    sign_ctrl_if.brick             sgn,
    output logic [2*`FU_NIB_W-1:0] prod
);

    // brick operand after extension by one sign bit
    localparam int EXT_W = `FU_BRICK_W + 1;
    // full brick product width
    localparam int BP_W  = 2 * EXT_W;
    localparam int CP_W  = 2 * `FU_NIB_W;
    localparam int BW    = `FU_BRICK_W;

    ////////////////////////////////////////
    // brick
    ////////////////////////////////////////

    // 2x2 product, each operand extended by its sign enable
    // unsigned operand gets a zero on top, signed one repeats its msb
    function automatic logic signed [BP_W-1:0] brick_mul(
        input logic [BW-1:0] a,
        input logic [BW-1:0] b,
        input logic          sa,
        input logic          sb
    );
        logic signed [EXT_W-1:0] ai;
        logic signed [EXT_W-1:0] bi;
        ai = {sa & a[BW-1], a};
        bi = {sb & b[BW-1], b};
        return ai * bi;
    endfunction

    // brick products, prefix gives x half then y half
    logic signed [BP_W-1:0] p_hh;
    logic signed [BP_W-1:0] p_hl;
    logic signed [BP_W-1:0] p_lh;
    logic signed [BP_W-1:0] p_ll;

    assign p_hh = brick_mul(x[CP_W/2-1:BW], y[CP_W/2-1:BW],
                            sgn.hh_sx[CLUSTER], sgn.hh_sy[CLUSTER]);
    assign p_hl = brick_mul(x[CP_W/2-1:BW], y[BW-1:0],
                            sgn.hl_sx[CLUSTER], sgn.hl_sy[CLUSTER]);
    assign p_lh = brick_mul(x[BW-1:0], y[CP_W/2-1:BW],
                            sgn.lh_sx[CLUSTER], sgn.lh_sy[CLUSTER]);
    assign p_ll = brick_mul(x[BW-1:0], y[BW-1:0],
                            sgn.ll_sx[CLUSTER], sgn.ll_sy[CLUSTER]);

    ////////////////////////////////////////
    // merge
    ////////////////////////////////////////

    // shifted terms, all taken mod 2^8
    logic [CP_W-1:0] t_ll;
    logic [CP_W-1:0] t_mid;
    logic [CP_W-1:0] t_hh;

    // low brick at weight 1, sign extended to the cluster width
    assign t_ll  = {{(CP_W-BP_W){p_ll[BP_W-1]}}, p_ll};
    // cross bricks at weight 4
    assign t_mid = {p_hl, {BW{1'b0}}} + {p_lh, {BW{1'b0}}};
    // high brick at weight 16, its upper bits fall off the word
    assign t_hh  = {p_hh[CP_W-2*BW-1:0], {(2*BW){1'b0}}};

    // exact 4x4 product in the signedness the enables describe
    assign prod = t_ll + t_mid + t_hh;

endmodule

//--- rtl/fusion_config.svh
`ifndef FUSION_CONFIG_SVH
`define FUSION_CONFIG_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// x and y operand width
`define FU_OPND_W   8
// one nibble, the operand of a cluster
`define FU_NIB_W    4
// one brick operand, before sign extension
`define FU_BRICK_W  2
// fused product word
`define FU_PROD_W   16
// running sum, 4 guard bits over the 8x8 product
`define FU_SUM_W    20

////////////////////////////////////////
// precision modes
////////////////////////////////////////

`define FU_MODE_W   2
`define FU_MODE_2B  2'd0
`define FU_MODE_4B  2'd1
`define FU_MODE_8B  2'd2
// unused code, also the stored mode out of reset
`define FU_MODE_NONE 2'd3

`endif

//--- rtl/fusion_core.sv
`timescale 1ns/1ps
`include "fusion_config.svh"

module fusion_core import fusion_pkg::*; (
    input  logic [`FU_OPND_W-1:0] x,
    input  logic [`FU_OPND_W-1:0] y,
    input  fu_mode_e              mode,
    sign_ctrl_if.brick            sgn,
    output fu_product_u           product
);

    localparam int NW   = `FU_NIB_W;
    // cluster product width
    localparam int CL_W = 2 * `FU_NIB_W;

    // keeps the upper brick of every nibble, 8'b1100_1100
    localparam logic [`FU_OPND_W-1:0] KEEP_MASK =
        {(`FU_OPND_W/`FU_NIB_W){{`FU_BRICK_W{1'b1}}, {`FU_BRICK_W{1'b0}}}};

    ////////////////////////////////////////
    // operand gating and split
    ////////////////////////////////////////

    logic [`FU_OPND_W-1:0] x_g;
    logic [`FU_OPND_W-1:0] y_g;

    // 2x2 mode uses only bits 7:6 and 3:2
    assign x_g = (mode == fu_mode_2b) ? (x & KEEP_MASK) : x;
    assign y_g = (mode == fu_mode_2b) ? (y & KEEP_MASK) : y;

    // cluster products, x nibble then y nibble
    logic [CL_W-1:0] pp_hh;
    logic [CL_W-1:0] pp_hl;
    logic [CL_W-1:0] pp_lh;
    logic [CL_W-1:0] pp_ll;

    bitbrick_cluster #(.CLUSTER(1)) u_cl_hh (
        .x(x_g[2*NW-1:NW]), .y(y_g[2*NW-1:NW]), .sgn(sgn), .prod(pp_hh)
    );
    bitbrick_cluster #(.CLUSTER(2)) u_cl_hl (
        .x(x_g[2*NW-1:NW]), .y(y_g[NW-1:0]), .sgn(sgn), .prod(pp_hl)
    );
    bitbrick_cluster #(.CLUSTER(3)) u_cl_lh (
        .x(x_g[NW-1:0]), .y(y_g[2*NW-1:NW]), .sgn(sgn), .prod(pp_lh)
    );
    bitbrick_cluster #(.CLUSTER(4)) u_cl_ll (
        .x(x_g[NW-1:0]), .y(y_g[NW-1:0]), .sgn(sgn), .prod(pp_ll)
    );

    ////////////////////////////////////////
    // product mapping
    ////////////////////////////////////////

    // signed cluster product widened to the 4x4 dot sum
    function automatic logic [QUAD_DOT_W-1:0] quad_term(input logic [CL_W-1:0] p);
        return {{(QUAD_DOT_W-CL_W){p[CL_W-1]}}, p};
    endfunction

    // in 2x2 mode only the high brick is nonzero, so bits 7:4 hold its product
    function automatic logic [DUAL_DOT_W-1:0] dual_term(input logic [CL_W-1:0] p);
        return {{(DUAL_DOT_W-NW){p[CL_W-1]}}, p[CL_W-1:NW]};
    endfunction

    always_comb begin
        product = '0;
        case (mode)
            fu_mode_8b: begin
                // hh on top, ll at bottom, cross terms sign extended at weight 16
                // ll is unsigned, the other three carry a sign
                product.full = {pp_hh, pp_ll}
                             + {({{NW{pp_hl[CL_W-1]}}, pp_hl}
                               + {{NW{pp_lh[CL_W-1]}}, pp_lh}), {NW{1'b0}}};
            end
            fu_mode_4b: begin
                product.quad.dot = quad_term(pp_hh) + quad_term(pp_hl)
                                 + quad_term(pp_lh) + quad_term(pp_ll);
            end
            fu_mode_2b: begin
                product.dual.dot = dual_term(pp_hh) + dual_term(pp_hl)
                                 + dual_term(pp_lh) + dual_term(pp_ll);
            end
            default: begin
                // code 3 gives a zero word
            end
        endcase
    end

endmodule

//--- rtl/fusion_mac.sv
`timescale 1ns/1ps
`include "fusion_config.svh"

module fusion_mac import fusion_pkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  en,
    input  logic [`FU_MODE_W-1:0] mode,
    input  logic [`FU_OPND_W-1:0] x,
    input  logic [`FU_OPND_W-1:0] y,
    output logic [`FU_PROD_W-1:0] product,
    output logic [`FU_SUM_W-1:0]  sum
);

    fu_mode_e    mode_e;
    fu_product_u prod_w;

    // all four codes are enum members
    assign mode_e  = fu_mode_e'(mode);
    assign product = prod_w.full;

    // sign enables for the sixteen bricks
    sign_ctrl_if u_sgn_if ();

    sign_ctrl u_sign_ctrl (
        .mode (mode_e),
        .sgn  (u_sgn_if.ctrl)
    );

    // combinational fused product
    fusion_core u_core (
        .x       (x),
        .y       (y),
        .mode    (mode_e),
        .sgn     (u_sgn_if.brick),
        .product (prod_w)
    );

    // registered running sum
    mac_accumulator u_acc (
        .clk     (clk),
        .nrst    (nrst),
        .en      (en),
        .mode    (mode_e),
        .product (prod_w),
        .sum     (sum)
    );

endmodule

//--- rtl/fusion_pkg.sv
`include "fusion_config.svh"

package fusion_pkg;

    ////////////////////////////////////////
    // derived widths
    ////////////////////////////////////////

    // 4x4 dot sum: 8-bit cluster product plus 2 bits of growth for 4 terms
    localparam int QUAD_DOT_W = 2 * `FU_NIB_W + 2;
    // 2x2 dot sum: 4-bit brick product plus 2 bits of growth
    localparam int DUAL_DOT_W = 2 * `FU_BRICK_W + 2;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // precision select
    typedef enum logic [`FU_MODE_W-1:0] {
        fu_mode_2b   = `FU_MODE_2B,
        fu_mode_4b   = `FU_MODE_4B,
        fu_mode_8b   = `FU_MODE_8B,
        fu_mode_none = `FU_MODE_NONE
    } fu_mode_e;

    // product word, every result is left aligned
    // full is used in 8x8 mode, quad in 4x4 mode, dual in 2x2 mode
    typedef union packed {
        logic [`FU_PROD_W-1:0] full;
        struct packed {
            logic [QUAD_DOT_W-1:0]            dot;
            // always zero in 4x4 mode
            logic [`FU_PROD_W-QUAD_DOT_W-1:0] pad;
        } quad;
        struct packed {
            logic [DUAL_DOT_W-1:0]            dot;
            // always zero in 2x2 mode
            logic [`FU_PROD_W-DUAL_DOT_W-1:0] pad;
        } dual;
    } fu_product_u;

endpackage

//--- rtl/mac_accumulator.sv
`timescale 1ns/1ps
`include "fusion_config.svh"

module mac_accumulator import fusion_pkg::*; (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 en,
    input  fu_mode_e             mode,
    input  fu_product_u          product,
    output logic [`FU_SUM_W-1:0] sum
);

    localparam int SW = `FU_SUM_W;
    localparam int PW = `FU_PROD_W;
    // left aligned sum fields, 12 bits for 4x4 and 10 bits for 2x2
    localparam int QUAD_FLD_W = QUAD_DOT_W + 2;
    localparam int DUAL_FLD_W = DUAL_DOT_W + 4;
    localparam int QUAD_LO    = SW - QUAD_FLD_W;
    localparam int DUAL_LO    = SW - DUAL_FLD_W;

    fu_mode_e mode_q;
    logic     mode_chg;

    // addends, sign extended to their field
    logic [SW-1:0]         full_ext;
    logic [QUAD_FLD_W-1:0] quad_ext;
    logic [DUAL_FLD_W-1:0] dual_ext;

    assign mode_chg = (mode != mode_q);

    assign full_ext = {{(SW-PW){product.full[PW-1]}}, product.full};
    assign quad_ext = {{(QUAD_FLD_W-QUAD_DOT_W){product.quad.dot[QUAD_DOT_W-1]}},
                       product.quad.dot};
    assign dual_ext = {{(DUAL_FLD_W-DUAL_DOT_W){product.dual.dot[DUAL_DOT_W-1]}},
                       product.dual.dot};

    ////////////////////////////////////////
    // accumulate
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            // stored mode never matches a live mode, so the first cycle clears
            mode_q <= fu_mode_none;
            sum    <= '0;
        end else begin
            mode_q <= mode;
            if (mode_chg) begin
                // new precision, start over
                sum <= '0;
            end else if (en) begin
                case (mode)
                    fu_mode_8b: sum <= sum + full_ext;
                    fu_mode_4b: begin
                        sum[SW-1:QUAD_LO] <= sum[SW-1:QUAD_LO] + quad_ext;
                        sum[QUAD_LO-1:0]  <= '0;
                    end
                    fu_mode_2b: begin
                        sum[SW-1:DUAL_LO] <= sum[SW-1:DUAL_LO] + dual_ext;
                        sum[DUAL_LO-1:0]  <= '0;
                    end
                    default: sum <= '0;
                endcase
            end
        end
    end

endmodule

//--- rtl/sign_ctrl.sv
`timescale 1ns/1ps

module sign_ctrl import fusion_pkg::*; (
    input  fu_mode_e    mode,
    sign_ctrl_if.ctrl   sgn
);

    // clusters whose x nibble is the high half of x (xh*yh, xh*yl)
    localparam logic [4:1] X_HI_CLUSTERS = 4'b0011;
    // clusters whose y nibble is the high half of y (xh*yh, xl*yh)
    localparam logic [4:1] Y_HI_CLUSTERS = 4'b0101;

    ////////////////////////////////////////
    // mode decode
    ////////////////////////////////////////

    // a brick operand is signed when it holds the sign bit
    // of an operand at the current precision
    always_comb begin
        // unsigned everywhere unless the mode says otherwise
        sgn.hh_sx = '0;
        sgn.hl_sx = '0;
        sgn.lh_sx = '0;
        sgn.ll_sx = '0;
        sgn.hh_sy = '0;
        sgn.hl_sy = '0;
        sgn.lh_sy = '0;
        sgn.ll_sy = '0;
        case (mode)
            fu_mode_2b: begin
                // every 2-bit slice is an operand of its own
                sgn.hh_sx = '1;
                sgn.hl_sx = '1;
                sgn.lh_sx = '1;
                sgn.ll_sx = '1;
                sgn.hh_sy = '1;
                sgn.hl_sy = '1;
                sgn.lh_sy = '1;
                sgn.ll_sy = '1;
            end
            fu_mode_4b: begin
                // bit 3 of each nibble sits in the upper brick operand
                sgn.hh_sx = '1;
                sgn.hl_sx = '1;
                sgn.hh_sy = '1;
                sgn.lh_sy = '1;
            end
            fu_mode_8b: begin
                // only the upper bricks of the upper nibbles see bit 7
                sgn.hh_sx = X_HI_CLUSTERS;
                sgn.hl_sx = X_HI_CLUSTERS;
                sgn.hh_sy = Y_HI_CLUSTERS;
                sgn.lh_sy = Y_HI_CLUSTERS;
            end
            default: begin
                // unused code, product is forced to zero downstream
            end
        endcase
    end

endmodule

//--- rtl/sign_ctrl_if.sv
`timescale 1ns/1ps

// per-brick sign enables, one bit per cluster
// cluster numbering: 1 = xh*yh, 2 = xh*yl, 3 = xl*yh, 4 = xl*yl
// prefix is the brick inside the cluster, first letter x half, second y half
interface sign_ctrl_if;

    // x operand of the brick taken as signed
    logic [4:1] hh_sx;
    logic [4:1] hl_sx;
    logic [4:1] lh_sx;
    logic [4:1] ll_sx;

    // y operand of the brick taken as signed
    logic [4:1] hh_sy;
    logic [4:1] hl_sy;
    logic [4:1] lh_sy;
    logic [4:1] ll_sy;

    // decoder side
    modport ctrl (
        output hh_sx, hl_sx, lh_sx, ll_sx,
        output hh_sy, hl_sy, lh_sy, ll_sy
    );

    // cluster side, each cluster picks its own bit
    modport brick (
        input hh_sx, hl_sx, lh_sx, ll_sx,
        input hh_sy, hl_sy, lh_sy, ll_sy
    );

endinterface

//--- testbench/fusion_mac_assertions.sv
`timescale 1ns/1ps
`include "fusion_config.svh"

// concurrent checks on the top level ports, bound into fusion_mac
module fusion_mac_assertions import fusion_pkg::*; (
    input logic                  clk,
    input logic                  nrst,
    input logic                  en,
    input logic [`FU_MODE_W-1:0] mode,
    input logic [`FU_PROD_W-1:0] product,
    input logic [`FU_SUM_W-1:0]  sum
);

    // failures so far, read by the testbench at the end of the run
    int fail_count = 0;

    fu_mode_e mode_e;

    assign mode_e = fu_mode_e'(mode);

    ////////////////////////////////////////
    // reset and mode change
    ////////////////////////////////////////

    // synchronous reset, sum is zero one cycle later
    reset_clears_sum: assert property (@(posedge clk) !nrst |=> sum == '0)
        else begin
            $error("sum is not zero after a reset cycle");
            fail_count++;
        end

    // the stored mode is last cycle's mode while out of reset
    change_clears_sum: assert property (@(posedge clk)
        nrst && $past(nrst) && mode != $past(mode) |=> sum == '0)
        else begin
            $error("sum is not cleared after a mode change");
            fail_count++;
        end

    // steady mode and en low, nothing moves
    hold_when_idle: assert property (@(posedge clk)
        nrst && $past(nrst) && !en && mode == $past(mode) |=> $stable(sum))
        else begin
            $error("sum changed while en was low");
            fail_count++;
        end

    ////////////////////////////////////////
    // zero fields of the left aligned words
    ////////////////////////////////////////

    quad_product_pad: assert property (@(posedge clk)
        mode_e == fu_mode_4b |-> product[5:0] == '0)
        else begin
            $error("low bits of the 4x4 product are not zero");
            fail_count++;
        end

    dual_product_pad: assert property (@(posedge clk)
        mode_e == fu_mode_2b |-> product[9:0] == '0)
        else begin
            $error("low bits of the 2x2 product are not zero");
            fail_count++;
        end

    // unused code
    none_product_zero: assert property (@(posedge clk)
        mode_e == fu_mode_none |-> product == '0)
        else begin
            $error("product is not zero for the unused mode");
            fail_count++;
        end

    quad_sum_pad: assert property (@(posedge clk)
        nrst && mode_e == fu_mode_4b |=> sum[7:0] == '0)
        else begin
            $error("low bits of the 4x4 sum are not zero");
            fail_count++;
        end

    dual_sum_pad: assert property (@(posedge clk)
        nrst && mode_e == fu_mode_2b |=> sum[9:0] == '0)
        else begin
            $error("low bits of the 2x2 sum are not zero");
            fail_count++;
        end

endmodule

bind fusion_mac fusion_mac_assertions u_chk (
    .clk     (clk),
    .nrst    (nrst),
    .en      (en),
    .mode    (mode),
    .product (product),
    .sum     (sum)
);

//--- testbench/fusion_mac_tb.sv
`timescale 1ns/1ps
`include "fusion_config.svh"

module fusion_mac_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    // random pairs per precision test
    localparam int PAIRS        = 40;
    // length of the fixed mode change sequence
    localparam int MODE_CYCLES  = 19;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + 3 * PAIRS + MODE_CYCLES;

    // en pattern of a phase
    localparam int EN_LOW  = 0;
    localparam int EN_HIGH = 1;
    localparam int EN_RAND = 2;

    logic                  clk;
    logic                  nrst;
    logic                  en;
    logic [`FU_MODE_W-1:0] mode;
    logic [`FU_OPND_W-1:0] x;
    logic [`FU_OPND_W-1:0] y;
    logic [`FU_PROD_W-1:0] product;
    logic [`FU_SUM_W-1:0]  sum;

    // shadow of the accumulator
    logic [`FU_SUM_W-1:0]  sum_ref;
    logic [`FU_MODE_W-1:0] mode_ref;
    logic [31:0]           lfsr;
    int                    check_count;
    int                    err_count;

    fusion_mac dut0 (
        .clk     (clk),
        .nrst    (nrst),
        .en      (en),
        .mode    (mode),
        .x       (x),
        .y       (y),
        .product (product),
        .sum     (sum)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog covers the whole sequence plus some slack
    initial begin
        #((TOTAL_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // signed 8x8
    function automatic int mul8(input logic [7:0] a, input logic [7:0] b);
        int p;
        p = $signed(a) * $signed(b);
        return p;
    endfunction

    // four signed nibble cross products
    function automatic int dot4(input logic [7:0] a, input logic [7:0] b);
        int ah;
        int al;
        int bh;
        int bl;
        ah = $signed(a[7:4]);
        al = $signed(a[3:0]);
        bh = $signed(b[7:4]);
        bl = $signed(b[3:0]);
        return ah * bh + ah * bl + al * bh + al * bl;
    endfunction

    // four signed 2-bit cross products of bits 7:6 and 3:2
    function automatic int dot2(input logic [7:0] a, input logic [7:0] b);
        int ah;
        int al;
        int bh;
        int bl;
        ah = $signed(a[7:6]);
        al = $signed(a[3:2]);
        bh = $signed(b[7:6]);
        bl = $signed(b[3:2]);
        return ah * bh + ah * bl + al * bh + al * bl;
    endfunction

    // left aligned product word
    function automatic logic [15:0] ref_product(input logic [1:0] m, input logic [7:0] a,
                                                input logic [7:0] b);
        case (m)
            `FU_MODE_8B: return 16'(mul8(a, b));
            `FU_MODE_4B: return {10'(dot4(a, b)), 6'b0};
            `FU_MODE_2B: return {6'(dot2(a, b)), 10'b0};
            default:     return '0;
        endcase
    endfunction

    // accumulator rules at one rising edge
    task automatic update_model(input logic [1:0] m, input logic [7:0] a,
                                input logic [7:0] b, input logic e);
        if (!nrst) begin
            sum_ref  = '0;
            mode_ref = `FU_MODE_NONE;
        end else begin
            if (m != mode_ref) begin
                sum_ref = '0;
            end else if (e) begin
                case (m)
                    `FU_MODE_8B: sum_ref = sum_ref + 20'(mul8(a, b));
                    `FU_MODE_4B: begin
                        sum_ref[19:8] = sum_ref[19:8] + 12'(dot4(a, b));
                        sum_ref[7:0]  = '0;
                    end
                    `FU_MODE_2B: begin
                        sum_ref[19:10] = sum_ref[19:10] + 10'(dot2(a, b));
                        sum_ref[9:0]   = '0;
                    end
                    default: sum_ref = '0;
                endcase
            end
            mode_ref = m;
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        repeat (n) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // called on a falling edge and returns on the next one
    task automatic run_cycle(input logic [1:0] m, input logic [7:0] a,
                             input logic [7:0] b, input logic e);
        logic [`FU_PROD_W-1:0] exp_prod;
        mode = m;
        x    = a;
        y    = b;
        en   = e;
        @(posedge clk);
        // product settled since the falling edge
        exp_prod = ref_product(m, a, b);
        check_count++;
        assert (product === exp_prod) else begin
            $display("Fail product: got %h, expected %h (mode %0d, x %h, y %h)",
                     product, exp_prod, m, a, b);
            err_count++;
        end
        update_model(m, a, b, e);
        @(negedge clk);
        check_count++;
        assert (sum === sum_ref) else begin
            $display("Fail sum: got %h, expected %h (mode %0d)", sum, sum_ref, m);
            err_count++;
        end
    endtask

    task automatic run_phase(input logic [1:0] m, input int n, input int en_kind);
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        logic       e;
        repeat (n) begin
            take_bits(8, a);
            take_bits(8, b);
            e = (en_kind == EN_HIGH);
            if (en_kind == EN_RAND) begin
                take_bits(1, r);
                e = r[0];
            end
            run_cycle(m, a, b, e);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s finished, %0d errors", num, name, err_count - errs_before);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int errs;
        int total_fail;
        nrst        = 1'b0;
        en          = 1'b0;
        mode        = `FU_MODE_NONE;
        x           = '0;
        y           = '0;
        lfsr        = 32'hc1a2b432;
        sum_ref     = '0;
        mode_ref    = `FU_MODE_NONE;
        check_count = 0;
        err_count   = 0;

        // reset held with random en
        // the first enabled cycle after release keeps the mode and must still clear
        errs = err_count;
        run_phase(`FU_MODE_8B, RESET_CYCLES, EN_RAND);
        nrst = 1'b1;
        run_phase(`FU_MODE_8B, 1, EN_HIGH);
        report_test(1, "reset", errs);

        errs = err_count;
        run_phase(`FU_MODE_8B, PAIRS, EN_RAND);
        report_test(2, "8x8 accumulation", errs);

        errs = err_count;
        run_phase(`FU_MODE_4B, PAIRS, EN_RAND);
        report_test(3, "4x4 accumulation", errs);

        errs = err_count;
        run_phase(`FU_MODE_2B, PAIRS, EN_RAND);
        report_test(4, "2x2 accumulation", errs);

        // build up a sum, hold it, then switch with en low and with en high
        errs = err_count;
        run_phase(`FU_MODE_8B, 4, EN_HIGH);
        run_phase(`FU_MODE_8B, 4, EN_LOW);
        run_phase(`FU_MODE_4B, 1, EN_LOW);
        run_phase(`FU_MODE_4B, 3, EN_HIGH);
        run_phase(`FU_MODE_2B, 3, EN_HIGH);
        run_phase(`FU_MODE_NONE, 3, EN_RAND);
        run_phase(`FU_MODE_8B, 1, EN_LOW);
        report_test(5, "mode change and hold", errs);

        total_fail = err_count + dut0.u_chk.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, err_count, dut0.u_chk.fail_count);
        if (total_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/fusion_pkg.sv
rtl/sign_ctrl_if.sv
rtl/sign_ctrl.sv
rtl/bitbrick_cluster.sv
rtl/fusion_core.sv
rtl/mac_accumulator.sv
rtl/fusion_mac.sv
testbench/fusion_mac_assertions.sv
testbench/fusion_mac_tb.sv
